//--- vlog.f
+incdir+tests
src/stopwatch_pkg.sv
src/button_conditioner.sv
src/tick_prescaler.sv
src/stopwatch_counter.sv
src/display_scanner.sv
src/stopwatch_top.sv
tests/tb_stopwatch.sv

//--- Makefile
# Verilator build and run for the stopwatch testbench

VERILATOR ?= verilator
TOP       ?= tb_stopwatch
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= SIMULATION PASSED

SRCS := $(wildcard src/*.sv) $(wildcard tests/*.sv) $(wildcard tests/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "run failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int value_errors   = 0;     // wrong values seen
int timeout_errors = 0;     // waits that ran out

task automatic check_time(input string name, input time_word_u got, input time_word_u exp);
    if (got !== exp) begin
        value_errors++;
        $display("** Error: %0t ns: %s = %h, expected %h", $time, name, got, exp);
    end
endtask

task automatic check_seg(input string name, input seg_t got, input seg_t exp);
    if (got !== exp) begin
        value_errors++;
        $display("** Error: %0t ns: %s = %b, expected %b", $time, name, got, exp);
    end
endtask

task automatic check_com(input string name, input com_t got, input com_t exp);
    if (got !== exp) begin
        value_errors++;
        $display("** Error: %0t ns: %s = %b, expected %b", $time, name, got, exp);
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        value_errors++;
        $display("** Error: %0t ns: %s = %b, expected %b", $time, name, got, exp);
    end
endtask

// counts kept by the testbench itself, e.g. running toggles
task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
        value_errors++;
        $display("** Error: %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
    end
endtask

// running reaches exp_run, at most limit cycles
task automatic wait_press_settle(input logic exp_run, input int limit);
    int n;
    n = 0;
    while (running !== exp_run && n < limit) begin
        next_cycle();
        n++;
    end
    if (running !== exp_run) begin
        timeout_errors++;
        $display("timeout at %0t ns: running never became %b within %0d cycles",
                 $time, exp_run, limit);
    end
endtask

// time_value reaches target; optionally every change must be one second
task automatic wait_for_time(input time_word_u target, input bit check_steps, input int limit);
    time_word_u prev;
    int         n;
    prev = time_value;
    n    = 0;
    while (time_value !== target && n < limit) begin
        next_cycle();
        n++;
        if (check_steps && time_value !== prev) begin
            check_time("time_value", time_value, one_second_later(prev));
            check_bit("time_value digits legal", digits_legal(time_value), 1'b1);
        end
        prev = time_value;
    end
    if (time_value !== target) begin
        timeout_errors++;
        $display("timeout at %0t ns: time_value stuck at %h, never reached %h in %0d cycles",
                 $time, time_value, target, limit);
    end
endtask

`endif

//--- tests/tb_stopwatch.sv
`timescale 1ns/1ns

module tb_stopwatch;

    import stopwatch_pkg::*;

    localparam int SAMPLE_CLKS = 4;     // short periods for simulation
    localparam int TICK_CLKS   = 20;
    localparam int SCAN_CLKS   = 8;
    localparam int SETTLE      = 2 * SAMPLE_CLKS + 8;   // button to effect, with margin
    localparam int HOLD_CLKS   = 20;                     // button held this long

    logic       clk;
    logic       reset_p;
    logic       btn_start;
    logic       btn_clear;
    logic       running;
    time_word_u time_value;
    com_t       com;
    seg_t       seg_7;

    logic last_running;     // running at the previous falling edge
    int   run_toggles;      // running changes seen
    int   cycle_no;         // falling edges since reset
    int   press_cycle;      // cycle the button went high

    stopwatch_top #(
        .SAMPLE_CLKS (SAMPLE_CLKS),
        .TICK_CLKS   (TICK_CLKS),
        .SCAN_CLKS   (SCAN_CLKS)
    ) UUT (
        .clk        (clk),
        .reset_p    (reset_p),
        .btn_start  (btn_start),
        .btn_clear  (btn_clear),
        .running    (running),
        .time_value (time_value),
        .com        (com),
        .seg_7      (seg_7)
    );

    always #5 clk = ~clk;   // 10 ns

    // all driving and sampling happens right after the falling edge
    task automatic next_cycle();
        @(negedge clk);
        cycle_no++;
        if (running !== last_running)
            run_toggles++;
        last_running = running;
    endtask

    // mm:ss in bcd, digits view
    function automatic time_word_u make_time(input int mm, input int ss);
        time_word_u t;
        t.digits[3] = digit_t'(mm / 10);
        t.digits[2] = digit_t'(mm % 10);
        t.digits[1] = digit_t'(ss / 10);
        t.digits[0] = digit_t'(ss % 10);
        return t;
    endfunction

    // plain seconds arithmetic, mod one hour
    function automatic time_word_u one_second_later(input time_word_u t);
        int secs;
        secs = (int'(t.digits[3]) * 10 + int'(t.digits[2])) * 60
             + int'(t.digits[1]) * 10 + int'(t.digits[0]);
        secs = (secs + 1) % 3600;
        return make_time(secs / 60, secs % 60);
    endfunction

    function automatic logic digits_legal(input time_word_u t);
        return (int'(t.digits[0]) <= 9) && (int'(t.digits[1]) <= 5)
            && (int'(t.digits[2]) <= 9) && (int'(t.digits[3]) <= 5);
    endfunction

    function automatic com_t ring_next(input com_t c);
        case (c)
            4'b1110: return 4'b1101;
            4'b1101: return 4'b1011;
            4'b1011: return 4'b0111;
            4'b0111: return 4'b1110;
            default: return 4'bxxxx;    // never matches
        endcase
    endfunction

    // lit digit from the anode select, -1 if not one-hot-low
    function automatic int digit_index(input com_t c);
        case (c)
            4'b1110: return 0;
            4'b1101: return 1;
            4'b1011: return 2;
            4'b0111: return 3;
            default: return -1;
        endcase
    endfunction

    `include "tb_checks.svh"

    task automatic drive_btn(input bit use_clear, input logic v);
        if (use_clear)
            btn_clear = v;
        else
            btn_start = v;
    endtask

    // bounce window kept under one sample period, so one edge only
    task automatic bounce_btn(input bit use_clear);
        int i;
        for (i = 0; i < SAMPLE_CLKS - 1; i++) begin
            drive_btn(use_clear, 1'($urandom % 2));
            next_cycle();
        end
    endtask

    task automatic press_button(input bit use_clear, input bit bounce);
        if (bounce)
            bounce_btn(use_clear);
        drive_btn(use_clear, 1'b1);     // stable from here
        press_cycle = cycle_no;
    endtask

    task automatic release_button(input bit use_clear, input bit bounce);
        while (cycle_no - press_cycle < HOLD_CLKS)
            next_cycle();
        if (bounce)
            bounce_btn(use_clear);
        drive_btn(use_clear, 1'b0);
        next_cycle();
    endtask

    task automatic test_reset();
        check_bit("running", running, 1'b0);
        check_time("time_value", time_value, make_time(0, 0));
        check_com("com", com, 4'b1110);
        check_seg("seg_7", seg_7, SEG_TABLE[0]);
    endtask

    task automatic test_start_stop();
        time_word_u frozen;
        logic       stable;
        int         i;
        run_toggles = 0;
        press_button(0, 1);
        wait_press_settle(1'b1, SETTLE);
        release_button(0, 1);
        repeat (SETTLE) next_cycle();       // release bounce must not toggle
        check_count("run_toggles", run_toggles, 1);
        check_bit("running", running, 1'b1);
        press_button(0, 1);                 // stop
        wait_press_settle(1'b0, SETTLE);
        release_button(0, 1);
        repeat (SETTLE) next_cycle();
        check_count("run_toggles", run_toggles, 2);
        frozen = time_value;
        stable = 1'b1;
        for (i = 0; i < 200 && stable; i++) begin
            next_cycle();
            if (time_value !== frozen)
                stable = 1'b0;      // first drift only
        end
        check_time("time_value", time_value, frozen);
    endtask

    task automatic test_clear();
        press_button(0, 0);
        wait_press_settle(1'b1, SETTLE);
        release_button(0, 0);
        wait_for_time(make_time(0, 2), 1'b1, 4 * TICK_CLKS + SETTLE);
        press_button(1, 1);                 // clear while running
        wait_for_time(make_time(0, 0), 1'b0, SETTLE);
        check_bit("running", running, 1'b1);
        release_button(1, 1);
        wait_for_time(make_time(0, 1), 1'b1, 2 * TICK_CLKS + SETTLE);
        press_button(0, 0);                 // stop at a nonzero time
        wait_press_settle(1'b0, SETTLE);
        release_button(0, 0);
        press_button(1, 1);                 // clear while stopped
        wait_for_time(make_time(0, 0), 1'b0, SETTLE);
        check_bit("running", running, 1'b0);
        release_button(1, 1);
    endtask

    task automatic test_counting();
        press_button(0, 0);
        wait_press_settle(1'b1, SETTLE);
        release_button(0, 0);
        wait_for_time(make_time(0, 59), 1'b1, 60 * TICK_CLKS + SETTLE);
        wait_for_time(make_time(1, 0), 1'b1, 2 * TICK_CLKS);   // carry into minutes
        wait_for_time(make_time(1, 23), 1'b1, 25 * TICK_CLKS);
        press_button(0, 0);                 // leave it stopped for the scan test
        wait_press_settle(1'b0, SETTLE);
        release_button(0, 0);
    endtask

    task automatic test_scan();
        com_t prev_com;
        int   rotations;
        int   idx;
        int   i;
        prev_com  = com;
        rotations = 0;
        for (i = 0; i < 100; i++) begin
            next_cycle();
            if (com !== prev_com) begin
                check_com("com", com, ring_next(prev_com));
                rotations++;
            end
            idx = digit_index(com);
            if (idx < 0)
                check_bit("com one-hot-low", 1'b0, 1'b1);
            else
                check_seg("seg_7", seg_7, SEG_TABLE[time_value.digits[idx]]);
            prev_com = com;
        end
        if (rotations < 100 / SCAN_CLKS - 1)
            check_count("com rotations", rotations, 100 / SCAN_CLKS);
    endtask

    initial begin
        void'($urandom(32'h624895be));     // one seed for the run
        clk          = 1'b0;
        reset_p      = 1'b1;
        btn_start    = 1'b0;
        btn_clear    = 1'b0;
        last_running = 1'b0;
        run_toggles  = 0;
        cycle_no     = 0;
        press_cycle  = 0;
        repeat (10) @(negedge clk);
        reset_p = 1'b0;
        test_reset();
        test_start_stop();
        test_clear();
        test_counting();
        test_scan();
        $display("errors: %0d value, %0d timeout", value_errors, timeout_errors);
        if (value_errors + timeout_errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- src/stopwatch_top.sv
`timescale 1ns/1ns

module stopwatch_top #(
    parameter int SAMPLE_CLKS = stopwatch_pkg::DEF_SAMPLE_CLKS,   // button sampling
    parameter int TICK_CLKS   = stopwatch_pkg::DEF_TICK_CLKS,     // one second
    parameter int SCAN_CLKS   = stopwatch_pkg::DEF_SCAN_CLKS      // per digit
) (
    input  logic                      clk,
    input  logic                      reset_p,
    input  logic                      btn_start,    // raw button
    input  logic                      btn_clear,    // raw button
    output logic                      running,
    output stopwatch_pkg::time_word_u time_value,   // to the leds
    output stopwatch_pkg::com_t       com,
    output stopwatch_pkg::seg_t       seg_7
);

    logic start_press;      // one-clock pulses from the buttons
    logic clear_press;

    // decode
    button_conditioner #(
        .SAMPLE_CLKS (SAMPLE_CLKS)
    ) start_btn (
        .clk     (clk),
        .reset_p (reset_p),
        .btn     (btn_start),
        .press   (start_press)
    );

    button_conditioner #(
        .SAMPLE_CLKS (SAMPLE_CLKS)
    ) clear_btn (
        .clk     (clk),
        .reset_p (reset_p),
        .btn     (btn_clear),
        .press   (clear_press)
    );

    // execute
    stopwatch_counter #(
        .TICK_CLKS (TICK_CLKS)
    ) counter (
        .clk         (clk),
        .reset_p     (reset_p),
        .start_press (start_press),
        .clear_press (clear_press),
        .running     (running),
        .time_value  (time_value)
    );

    // result
    display_scanner #(
        .SCAN_CLKS (SCAN_CLKS)
    ) scanner (
        .clk        (clk),
        .reset_p    (reset_p),
        .time_value (time_value),
        .com        (com),
        .seg_7      (seg_7)
    );

endmodule

//--- src/display_scanner.sv
`timescale 1ns/1ns

module display_scanner #(
    parameter int SCAN_CLKS = stopwatch_pkg::DEF_SCAN_CLKS
) (
    input  logic                      clk,
    input  logic                      reset_p,
    input  stopwatch_pkg::time_word_u time_value,
    output stopwatch_pkg::com_t       com,      // anode ring, active low
    output stopwatch_pkg::seg_t       seg_7     // segments of the lit digit
);

    import stopwatch_pkg::*;

    localparam int CW = $clog2(SCAN_CLKS);
    localparam int SW = $clog2(NUM_DIGITS);

    logic [CW-1:0] scan_cnt;        // time per digit
    logic          scan_stb;
    com_t          com_next;        // ring value for the next cycle
    logic [SW-1:0] sel;             // digit index picked by com_next
    digit_t        digit;

    assign scan_stb = (scan_cnt == CW'(SCAN_CLKS - 1));

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p)
            scan_cnt <= '0;
        else if (scan_stb)
            scan_cnt <= '0;
        else
            scan_cnt <= scan_cnt + 1'b1;
    end

    // 1110 -> 1101 -> 1011 -> 0111 -> 1110
    assign com_next = scan_stb ? {com[NUM_DIGITS-2:0], com[NUM_DIGITS-1]} : com;

    // one-hot-low to index
    always_comb begin
        sel = '0;
        for (int i = 0; i < NUM_DIGITS; i++) begin
            if (!com_next[i])
                sel = SW'(i);
        end
    end

    assign digit = time_value.digits[sel];     // nibble view of the time word

    // ring and pattern registered together so they always match
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            com   <= com_t'(4'b1110);     // rightmost digit first
            seg_7 <= SEG_TABLE[0];
        end else begin
            com   <= com_next;
            seg_7 <= SEG_TABLE[digit];
        end
    end

endmodule

//--- src/stopwatch_counter.sv
`timescale 1ns/1ns

module stopwatch_counter #(
    parameter int TICK_CLKS = stopwatch_pkg::DEF_TICK_CLKS
) (
    input  logic                     clk,
    input  logic                     reset_p,
    input  logic                     start_press,   // toggles running
    input  logic                     clear_press,   // zeroes the time
    output logic                     running,
    output stopwatch_pkg::time_word_u time_value
);

    import stopwatch_pkg::*;

    logic       tick;           // one second
    time_word_u time_next;      // time_value plus one second

    tick_prescaler #(
        .TICK_CLKS (TICK_CLKS)
    ) prescaler (
        .clk     (clk),
        .reset_p (reset_p),
        .run     (running),
        .clear   (clear_press),
        .tick    (tick)
    );

    // start/stop, a t flip-flop on the press pulse
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p)
            running <= 1'b0;
        else if (start_press)
            running <= ~running;
    end

    // bcd increment with ripple carry, 59:59 wraps to 00:00
    always_comb begin
        time_next = time_value;
        if (time_value.fields.sec.units >= 4'd9) begin
            time_next.fields.sec.units = '0;
            if (time_value.fields.sec.tens >= 4'd5) begin
                time_next.fields.sec.tens = '0;         // carry into minutes
                if (time_value.fields.min.units >= 4'd9) begin
                    time_next.fields.min.units = '0;
                    if (time_value.fields.min.tens >= 4'd5)
                        time_next.fields.min.tens = '0;     // hour rollover
                    else
                        time_next.fields.min.tens = time_value.fields.min.tens + 4'd1;
                end else begin
                    time_next.fields.min.units = time_value.fields.min.units + 4'd1;
                end
            end else begin
                time_next.fields.sec.tens = time_value.fields.sec.tens + 4'd1;
            end
        end else begin
            time_next.fields.sec.units = time_value.fields.sec.units + 4'd1;
        end
    end

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p)
            time_value <= '0;
        else if (clear_press)
            time_value <= '0;           // clear wins over tick
        else if (tick)
            time_value <= time_next;
    end

endmodule

//--- src/tick_prescaler.sv
`timescale 1ns/1ns

module tick_prescaler #(
    parameter int TICK_CLKS = stopwatch_pkg::DEF_TICK_CLKS
) (
    input  logic clk,
    input  logic reset_p,
    input  logic run,       // count only while high
    input  logic clear,     // restart the period
    output logic tick       // one clock per period
);

    localparam int CW = $clog2(TICK_CLKS);

    logic [CW-1:0] cnt;
    logic          last;

    assign last = (cnt == CW'(TICK_CLKS - 1));

    // one counter in place of the /100 and /1000 chain
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else if (clear || !run) begin
            cnt  <= '0;             // restart gives a full period
            tick <= 1'b0;
        end else if (last) begin
            cnt  <= '0;
            tick <= 1'b1;           // period done
        end else begin
            cnt  <= cnt + 1'b1;
            tick <= 1'b0;
        end
    end

endmodule

//--- src/button_conditioner.sv
`timescale 1ns/1ns

module button_conditioner #(
    parameter int SAMPLE_CLKS = stopwatch_pkg::DEF_SAMPLE_CLKS
) (
    input  logic clk,
    input  logic reset_p,
    input  logic btn,       // raw level, may bounce
    output logic press      // one clock per press
);

    localparam int CW = $clog2(SAMPLE_CLKS);

    logic [CW-1:0] sample_cnt;      // sample period counter
    logic          sample_stb;
    logic          btn_sync;        // raw button into clk domain
    logic          level;           // debounced level
    logic          level_d;         // previous debounced level

    assign sample_stb = (sample_cnt == CW'(SAMPLE_CLKS - 1));

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            sample_cnt <= '0;
        end else if (sample_stb) begin
            sample_cnt <= '0;               // wrap
        end else begin
            sample_cnt <= sample_cnt + 1'b1;
        end
    end

    // bounces shorter than one sample period never reach level
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            btn_sync <= 1'b0;
            level    <= 1'b0;
            level_d  <= 1'b0;
            press    <= 1'b0;
        end else begin
            btn_sync <= btn;
            if (sample_stb)
                level <= btn_sync;          // only look at the button on the strobe
            level_d  <= level;
            press    <= level & ~level_d;   // rising edge, one pulse while held
        end
    end

endmodule

//--- src/stopwatch_pkg.sv
package stopwatch_pkg;

    localparam int NUM_DIGITS = 4;              // fnd digits on the board

    typedef logic [3:0]            digit_t;     // one bcd or hex digit
    typedef logic [7:0]            seg_t;       // abcd_efgp, active low
    typedef logic [NUM_DIGITS-1:0] com_t;       // anode select, active low

    // one time word, two readings
    typedef union packed {
        digit_t [NUM_DIGITS-1:0] digits;        // digits[0] = seconds units
        struct packed {
            struct packed {
                digit_t tens;
                digit_t units;
            } min;                              // upper byte
            struct packed {
                digit_t tens;
                digit_t units;
            } sec;                              // lower byte
        } fields;
    } time_word_u;

    // hex to segment, abcd_efgp, 0 = segment lit
    localparam seg_t SEG_TABLE [16] = '{
        8'b0000_0011, 8'b1001_1111, 8'b0010_0101, 8'b0000_1101,   // 0 1 2 3
        8'b1001_1001, 8'b0100_1001, 8'b0100_0001, 8'b0001_1011,   // 4 5 6 7
        8'b0000_0001, 8'b0000_1001, 8'b0001_0001, 8'b1100_0001,   // 8 9 A b
        8'b0110_0011, 8'b1000_0101, 8'b0110_0001, 8'b0111_0001    // C d E F
    };

    // periods in system clocks, 100 MHz board
    localparam int DEF_SAMPLE_CLKS = 65536;         // ~0.65 ms button sampling
    localparam int DEF_TICK_CLKS   = 100_000_000;   // 1 s
    localparam int DEF_SCAN_CLKS   = 65536;         // per-digit scan slot

endpackage
